// ==== exception_unit.f ====
+incdir+tb
src/csr_pkg.sv
src/trap_pkg.sv
src/csr_file.sv
src/csr_port_arbiter.sv
src/trap_sequencer.sv
src/exception_unit.sv
tb/exception_unit_tb.sv

// ==== tb/exception_unit_vectors.svh ====
task automatic load_rows();
    // Reset values
    expect_row(csr_pkg::addr_mstatus, 32'h0);
    expect_row(csr_pkg::addr_mie, 32'h0);
    expect_row(csr_pkg::addr_mtvec, reset_vector);
    expect_row(csr_pkg::addr_mepc, 32'h0);
    expect_row(csr_pkg::addr_mcause, 32'h0);
    expect_row(csr_pkg::addr_mtval, 32'h0);
    expect_row(csr_pkg::addr_mip, 32'h0);
    expect_row(12'h7c0, 32'h0);                     // No CSR here

    // ########################################################################
    // CSR instructions on random data
    // ########################################################################
    csr_row(csr_pkg::op_write, csr_pkg::addr_mie, 1'b0, 1'b1, '0);
    read_row(csr_pkg::addr_mie);
    csr_row(csr_pkg::op_set, csr_pkg::addr_mie, 1'b1, 1'b1, '0);
    read_row(csr_pkg::addr_mie);
    csr_row(csr_pkg::op_clear, csr_pkg::addr_mie, 1'b0, 1'b1, '0);
    read_row(csr_pkg::addr_mie);
    csr_row(csr_pkg::op_clear, csr_pkg::addr_mie, 1'b1, 1'b1, '0);
    read_row(csr_pkg::addr_mie);
    csr_row(csr_pkg::op_write, csr_pkg::addr_mtval, 1'b1, 1'b1, '0);
    read_row(csr_pkg::addr_mtval);
    csr_row(csr_pkg::op_set, csr_pkg::addr_mip, 1'b0, 1'b1, '0);
    csr_row(csr_pkg::op_clear, csr_pkg::addr_mip, 1'b0, 1'b1, '0);
    read_row(csr_pkg::addr_mip);
    csr_row(csr_pkg::op_write, csr_pkg::addr_mepc, 1'b0, 1'b1, '0);
    read_row(csr_pkg::addr_mepc);
    csr_row(csr_pkg::op_write, 12'h7c0, 1'b0, 1'b1, '0);
    expect_row(12'h7c0, 32'h0);                     // Write was ignored
    csr_row(csr_pkg::op_write, csr_pkg::addr_mstatus, 1'b0, 1'b1, '0);
    read_row(csr_pkg::addr_mstatus);

    // Exceptions, each in turn
    csr_row(csr_pkg::op_set, csr_pkg::addr_mstatus, 1'b1, 1'b0, 32'h8);
    trap_row(5'b01000, 32'h0000_1000, 5'b11111, 1'b0);
    read_row(csr_pkg::addr_mepc);
    expect_row(csr_pkg::addr_mcause, 32'd2);
    read_row(csr_pkg::addr_mstatus);
    csr_row(csr_pkg::op_set, csr_pkg::addr_mstatus, 1'b1, 1'b0, 32'h8);
    trap_row(5'b00100, 32'h0000_1004, 5'b11111, 1'b0);
    expect_row(csr_pkg::addr_mcause, 32'd5);
    read_row(csr_pkg::addr_mepc);
    trap_row(5'b00010, 32'h0000_1008, 5'b11111, 1'b0);
    expect_row(csr_pkg::addr_mcause, 32'd7);
    read_row(csr_pkg::addr_mstatus);
    trap_row(5'b00001, 32'h0000_100c, 5'b11111, 1'b0);
    expect_row(csr_pkg::addr_mcause, 32'd11);

    // Interrupt keeps the writeback and saves epc_next
    csr_row(csr_pkg::op_set, csr_pkg::addr_mstatus, 1'b1, 1'b0, 32'h8);
    trap_row(5'b10000, 32'h0000_2000, 5'b11110, 1'b0);
    read_row(csr_pkg::addr_mepc);
    expect_row(csr_pkg::addr_mcause, 32'h8000_000B);
    read_row(csr_pkg::addr_mstatus);

    // ########################################################################
    // mret with MPIE set, then with MPIE clear
    // ########################################################################
    mret_row(5'b11110);
    read_row(csr_pkg::addr_mstatus);
    csr_row(csr_pkg::op_clear, csr_pkg::addr_mstatus, 1'b0, 1'b0, 32'h0000_0080);
    mret_row(5'b11110);
    read_row(csr_pkg::addr_mstatus);

    // Simultaneous causes, some with a CSR write that must be dropped
    trap_row(5'b01001, 32'h0000_3000, 5'b11111, 1'b0);
    expect_row(csr_pkg::addr_mcause, 32'd2);
    trap_row(5'b00111, 32'h0000_3004, 5'b11111, 1'b1);
    expect_row(csr_pkg::addr_mcause, 32'd11);
    read_row(csr_pkg::addr_mtval);
    trap_row(5'b11111, 32'h0000_3008, 5'b11110, 1'b1);
    expect_row(csr_pkg::addr_mcause, 32'h8000_000B);
    read_row(csr_pkg::addr_mepc);
    read_row(csr_pkg::addr_mtval);
endtask

// ==== tb/exception_unit_tb.sv ====
module exception_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam csr_pkg::csr_data_t reset_vector = 32'h0000_0100;

    typedef enum logic [1:0] {
        kind_csr,
        kind_trap,
        kind_mret
    } row_kind_t;

    // One operation of the table
    typedef struct packed {
        row_kind_t             kind;
        csr_pkg::csr_op_t      op;
        csr_pkg::csr_addr_t    addr;
        logic                  imm_sel;
        logic                  rnd;        // Replace data with a random value
        csr_pkg::csr_data_t    data;       // Source operand, or epc_cur of a trap
        trap_pkg::trap_cause_t cause;
        logic                  late;       // CSR write in T+1 of the trap
        logic                  exp_chk;
        csr_pkg::csr_data_t    exp_rdata;
        trap_pkg::flush_t      exp_flush;  // Flushes in the first cycle
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  csr_rw;
    csr_pkg::csr_op_t      csr_op;
    csr_pkg::csr_addr_t    csr_addr;
    logic                  imm_sel;
    csr_pkg::csr_data_t    rs1_data;
    csr_pkg::csr_imm_t     imm;
    csr_pkg::csr_data_t    csr_rdata;
    trap_pkg::trap_cause_t cause;
    logic                  mret;
    csr_pkg::csr_data_t    epc_cur;
    csr_pkg::csr_data_t    epc_next;
    logic                  redirect;
    csr_pkg::csr_data_t    redirect_pc;
    trap_pkg::flush_t      flush;

    row_t               rows[$];
    csr_pkg::csr_data_t model_mem [0:4095];    // Expected CSR contents by address
    int                 seed = 32'hbc99;
    int                 cycles = 0;
    int                 cycle_limit;

    exception_unit #(
        .reset_vector (reset_vector)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .csr_rw      (csr_rw),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .imm_sel     (imm_sel),
        .rs1_data    (rs1_data),
        .imm         (imm),
        .csr_rdata   (csr_rdata),
        .cause       (cause),
        .mret        (mret),
        .epc_cur     (epc_cur),
        .epc_next    (epc_next),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input csr_pkg::csr_data_t actual,
                               input csr_pkg::csr_data_t expected);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic logic implemented(input csr_pkg::csr_addr_t addr);
        case (addr)
            csr_pkg::addr_mstatus, csr_pkg::addr_mie, csr_pkg::addr_mtvec,
            csr_pkg::addr_mepc, csr_pkg::addr_mcause, csr_pkg::addr_mtval,
            csr_pkg::addr_mip: return 1'b1;
            default:           return 1'b0;
        endcase
    endfunction

    task automatic model_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_t op,
                               input csr_pkg::csr_data_t src);
        csr_pkg::csr_data_t cur;
        cur = model_mem[addr];
        case (op)
            csr_pkg::op_write: cur = src;
            csr_pkg::op_set:   cur = cur | src;
            csr_pkg::op_clear: cur = cur & ~src;
            default: ;
        endcase
        if (implemented(addr)) model_mem[addr] = cur;
    endtask

    // Priority is interrupt, illegal, ecall, load fault, store fault
    function automatic csr_pkg::csr_data_t expected_cause(input trap_pkg::trap_cause_t c);
        if (c.interrupt)         return 32'h8000_000B;
        else if (c.illegal_inst) return 32'd2;
        else if (c.ecall)        return 32'd11;
        else if (c.load_fault)   return 32'd5;
        else                     return 32'd7;
    endfunction

    // ########################################################################
    // Table rows and stimulus
    // ########################################################################

    task automatic csr_row(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                           input logic sel, input logic rnd, input csr_pkg::csr_data_t data);
        row_t r;
        r         = '0;
        r.kind    = kind_csr;
        r.op      = op;
        r.addr    = addr;
        r.imm_sel = sel;
        r.rnd     = rnd;
        r.data    = data;
        rows.push_back(r);
    endtask

    task automatic read_row(input csr_pkg::csr_addr_t addr);
        csr_row(csr_pkg::op_set, addr, 1'b0, 1'b0, '0);    // Set with zero leaves it as is
    endtask

    task automatic expect_row(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t value);
        read_row(addr);
        rows[$].exp_chk   = 1'b1;
        rows[$].exp_rdata = value;
    endtask

    task automatic trap_row(input trap_pkg::trap_cause_t c, input csr_pkg::csr_data_t epc,
                            input trap_pkg::flush_t fl, input logic late);
        row_t r;
        r           = '0;
        r.kind      = kind_trap;
        r.cause     = c;
        r.data      = epc;
        r.exp_flush = fl;
        r.late      = late;
        rows.push_back(r);
    endtask

    task automatic mret_row(input trap_pkg::flush_t fl);
        row_t r;
        r           = '0;
        r.kind      = kind_mret;
        r.exp_flush = fl;
        rows.push_back(r);
    endtask

    `include "exception_unit_vectors.svh"

    task automatic idle_inputs();
        csr_rw   <= 1'b0;
        csr_op   <= csr_pkg::op_write;
        csr_addr <= '0;
        imm_sel  <= 1'b0;
        rs1_data <= '0;
        imm      <= '0;
        cause    <= '0;
        mret     <= 1'b0;
        epc_cur  <= '0;
        epc_next <= '0;
    endtask

    task automatic apply_row(input row_t r);
        csr_pkg::csr_data_t data;
        csr_pkg::csr_data_t mst;
        if (r.rnd) data = $random(seed);
        else data = r.data;
        @(posedge clk);
        idle_inputs();
        case (r.kind)
            kind_csr: begin
                csr_rw   <= 1'b1;
                csr_op   <= r.op;
                csr_addr <= r.addr;
                imm_sel  <= r.imm_sel;
                rs1_data <= data;
                imm      <= data[4:0];
                @(negedge clk);
                check_value("csr_rdata", csr_rdata, model_mem[r.addr]);    // Old value
                if (r.exp_chk) check_value("csr_rdata", csr_rdata, r.exp_rdata);
                check_value("redirect", redirect, 1'b0);
                check_value("flush", flush, r.exp_flush);
                model_write(r.addr, r.op, r.imm_sel ? {27'b0, data[4:0]} : data);
            end
            kind_trap: begin
                cause    <= r.cause;
                epc_cur  <= data;
                epc_next <= data + 32'd4;
                @(negedge clk);
                check_value("flush", flush, r.exp_flush);
                check_value("redirect", redirect, 1'b0);
                mst                        = model_mem[csr_pkg::addr_mstatus];
                mst[csr_pkg::mstatus_mpie] = mst[csr_pkg::mstatus_mie];
                mst[csr_pkg::mstatus_mie]  = 1'b0;
                model_mem[csr_pkg::addr_mstatus] = mst;
                @(posedge clk);
                idle_inputs();
                if (r.late) begin
                    csr_rw   <= 1'b1;
                    csr_addr <= csr_pkg::addr_mtval;
                    rs1_data <= ~model_mem[csr_pkg::addr_mtval];
                end
                @(negedge clk);
                check_value("redirect", redirect, 1'b1);
                check_value("redirect_pc", redirect_pc, model_mem[csr_pkg::addr_mtvec]);
                check_value("flush", flush, 5'b10000);    // Only fd
                model_mem[csr_pkg::addr_mepc] = r.cause.interrupt ? data + 32'd4 : data;
                @(posedge clk);
                idle_inputs();
                @(negedge clk);
                check_value("redirect", redirect, 1'b0);
                check_value("flush", flush, 5'b00000);
                model_mem[csr_pkg::addr_mcause] = expected_cause(r.cause);
            end
            default: begin
                mret <= 1'b1;
                @(negedge clk);
                check_value("redirect", redirect, 1'b1);
                check_value("redirect_pc", redirect_pc, model_mem[csr_pkg::addr_mepc]);
                check_value("flush", flush, r.exp_flush);
                mst                        = model_mem[csr_pkg::addr_mstatus];
                mst[csr_pkg::mstatus_mie]  = mst[csr_pkg::mstatus_mpie];
                mst[csr_pkg::mstatus_mpie] = 1'b1;
                model_mem[csr_pkg::addr_mstatus] = mst;
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        idle_inputs();
        load_rows();
        cycle_limit = rows.size() * 4 + 20;
        for (int i = 0; i < 4096; i++) model_mem[i] = '0;
        model_mem[csr_pkg::addr_mtvec] = reset_vector;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i]) apply_row(rows[i]);
        @(posedge clk);
        idle_inputs();
        repeat (2) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== src/exception_unit.sv ====
module exception_unit #(
    parameter csr_pkg::csr_data_t reset_vector = 32'h0000_0100
) (
    input  logic                  clk,
    input  logic                  rst,
    // CSR instruction
    input  logic                  csr_rw,
    input  csr_pkg::csr_op_t      csr_op,
    input  csr_pkg::csr_addr_t    csr_addr,
    input  logic                  imm_sel,
    input  csr_pkg::csr_data_t    rs1_data,
    input  csr_pkg::csr_imm_t     imm,
    output csr_pkg::csr_data_t    csr_rdata,
    // Traps and returns
    input  trap_pkg::trap_cause_t cause,
    input  logic                  mret,
    input  csr_pkg::csr_data_t    epc_cur,
    input  csr_pkg::csr_data_t    epc_next,
    output logic                  redirect,
    output csr_pkg::csr_data_t    redirect_pc,
    output trap_pkg::flush_t      flush
);

    csr_pkg::csr_req_t  port_req;
    csr_pkg::csr_data_t port_rdata;
    csr_pkg::csr_data_t mstatus;
    logic               seq_req_valid;
    csr_pkg::csr_req_t  seq_req;
    logic               vec_req_valid;
    csr_pkg::csr_addr_t vec_raddr;

    csr_file #(
        .reset_vector (reset_vector)
    ) u_csr_file (
        .clk     (clk),
        .rst     (rst),
        .req     (port_req),
        .rdata   (port_rdata),
        .mstatus (mstatus)
    );

    csr_port_arbiter u_arbiter (
        .clk           (clk),
        .seq_req_valid (seq_req_valid),
        .seq_req       (seq_req),
        .vec_req_valid (vec_req_valid),
        .vec_raddr     (vec_raddr),
        .csr_rw        (csr_rw),
        .csr_op        (csr_op),
        .csr_addr      (csr_addr),
        .imm_sel       (imm_sel),
        .rs1_data      (rs1_data),
        .imm           (imm),
        .port_req      (port_req),
        .port_rdata    (port_rdata),
        .rdata         (csr_rdata)
    );

    trap_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .cause         (cause),
        .mret          (mret),
        .epc_cur       (epc_cur),
        .epc_next      (epc_next),
        .mstatus       (mstatus),
        .rdata         (csr_rdata),    // Same port data, carries mtvec or mepc
        .seq_req_valid (seq_req_valid),
        .seq_req       (seq_req),
        .vec_req_valid (vec_req_valid),
        .vec_raddr     (vec_raddr),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .flush         (flush)
    );

endmodule

// ==== src/trap_sequencer.sv ====
module trap_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  trap_pkg::trap_cause_t cause,
    input  logic                  mret,
    input  csr_pkg::csr_data_t    epc_cur,
    input  csr_pkg::csr_data_t    epc_next,
    input  csr_pkg::csr_data_t    mstatus,
    input  csr_pkg::csr_data_t    rdata,
    output logic                  seq_req_valid,
    output csr_pkg::csr_req_t     seq_req,
    output logic                  vec_req_valid,
    output csr_pkg::csr_addr_t    vec_raddr,
    output logic                  redirect,
    output csr_pkg::csr_data_t    redirect_pc,
    output trap_pkg::flush_t      flush
);

    trap_pkg::trap_state_t state_q;
    trap_pkg::trap_state_t state_d;

    logic                  trap_in;
    trap_pkg::trap_cause_t cause_q;
    csr_pkg::csr_data_t    epc_cur_q;
    csr_pkg::csr_data_t    epc_next_q;
    csr_pkg::csr_data_t    mstatus_entry;
    csr_pkg::csr_data_t    mstatus_exit;

    // Highest priority first
    function automatic csr_pkg::csr_data_t cause_code(input trap_pkg::trap_cause_t c);
        if (c.interrupt)         return trap_pkg::code_interrupt;
        else if (c.illegal_inst) return trap_pkg::code_illegal;
        else if (c.ecall)        return trap_pkg::code_ecall;
        else if (c.load_fault)   return trap_pkg::code_load_fault;
        else if (c.store_fault)  return trap_pkg::code_store_fault;
        return '0;
    endfunction

    assign trap_in = |cause;

    always_comb begin
        mstatus_entry                        = mstatus;
        mstatus_entry[csr_pkg::mstatus_mpie] = mstatus[csr_pkg::mstatus_mie];
        mstatus_entry[csr_pkg::mstatus_mie]  = 1'b0;

        mstatus_exit                         = mstatus;
        mstatus_exit[csr_pkg::mstatus_mie]   = mstatus[csr_pkg::mstatus_mpie];
        mstatus_exit[csr_pkg::mstatus_mpie]  = 1'b1;
    end

    // ##########################################################################
    // State and captured trap context
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= trap_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == trap_pkg::idle && trap_in) begin
            cause_q    <= cause;
            epc_cur_q  <= epc_cur;
            epc_next_q <= epc_next;
        end
    end

    // ##########################################################################
    // Port requests, redirect and flushes
    // ##########################################################################

    always_comb begin
        state_d       = state_q;
        seq_req_valid = 1'b0;
        seq_req.we    = 1'b0;
        seq_req.op    = csr_pkg::op_write;
        seq_req.waddr = csr_pkg::addr_mstatus;
        seq_req.wdata = '0;
        seq_req.raddr = csr_pkg::addr_mstatus;
        vec_req_valid = 1'b0;
        vec_raddr     = csr_pkg::addr_mtvec;
        redirect      = 1'b0;
        flush         = '0;

        unique case (state_q)
            trap_pkg::idle: begin
                if (trap_in) begin
                    state_d               = trap_pkg::save_epc;
                    seq_req_valid         = 1'b1;
                    seq_req.we            = 1'b1;
                    seq_req.wdata         = mstatus_entry;
                    flush.fd              = 1'b1;
                    flush.de              = 1'b1;
                    flush.em              = 1'b1;
                    flush.mw              = 1'b1;
                    flush.regwrite_cancel = !cause.interrupt;    // Interrupted inst retires
                end else if (mret) begin
                    seq_req_valid = 1'b1;
                    seq_req.we    = 1'b1;
                    seq_req.wdata = mstatus_exit;
                    vec_req_valid = 1'b1;
                    vec_raddr     = csr_pkg::addr_mepc;
                    redirect      = 1'b1;
                    flush.fd      = 1'b1;
                    flush.de      = 1'b1;
                    flush.em      = 1'b1;
                    flush.mw      = 1'b1;
                end
            end
            trap_pkg::save_epc: begin
                state_d       = trap_pkg::save_cause;
                seq_req_valid = 1'b1;
                seq_req.we    = 1'b1;
                seq_req.waddr = csr_pkg::addr_mepc;
                seq_req.wdata = cause_q.interrupt ? epc_next_q : epc_cur_q;
                vec_req_valid = 1'b1;
                vec_raddr     = csr_pkg::addr_mtvec;
                redirect      = 1'b1;
                flush.fd      = 1'b1;    // Kill the fetch already in flight
            end
            trap_pkg::save_cause: begin
                state_d       = trap_pkg::idle;
                seq_req_valid = 1'b1;
                seq_req.we    = 1'b1;
                seq_req.waddr = csr_pkg::addr_mcause;
                seq_req.wdata = cause_code(cause_q);
            end
            default: state_d = trap_pkg::idle;
        endcase
    end

    assign redirect_pc = redirect ? rdata : '0;

    // Trap entry takes two busy states and then the sequencer is free again
    trap_returns_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == trap_pkg::idle && trap_in)
            |=> (state_q != trap_pkg::idle) [*2] ##1 (state_q == trap_pkg::idle)
    ) else $error("Trap sequence did not return to idle on time");

endmodule

// ==== src/csr_port_arbiter.sv ====
module csr_port_arbiter (
    input  logic               clk,
    // Trap sequencer
    input  logic               seq_req_valid,
    input  csr_pkg::csr_req_t  seq_req,
    input  logic               vec_req_valid,
    input  csr_pkg::csr_addr_t vec_raddr,
    // CSR instruction
    input  logic               csr_rw,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               imm_sel,
    input  csr_pkg::csr_data_t rs1_data,
    input  csr_pkg::csr_imm_t  imm,
    // CSR file
    output csr_pkg::csr_req_t  port_req,
    input  csr_pkg::csr_data_t port_rdata,
    output csr_pkg::csr_data_t rdata
);

    csr_pkg::csr_data_t inst_wdata;
    logic               inst_grant;

    assign inst_wdata = imm_sel ? {27'b0, imm} : rs1_data;    // zimm is zero-extended

    // Instruction only wins when the sequencer is quiet
    assign inst_grant = csr_rw && !seq_req_valid && !vec_req_valid;

    always_comb begin
        port_req.we    = 1'b0;
        port_req.op    = csr_pkg::op_write;
        port_req.waddr = '0;
        port_req.wdata = '0;
        port_req.raddr = '0;

        if (seq_req_valid) begin
            port_req.we    = seq_req.we;
            port_req.op    = seq_req.op;
            port_req.waddr = seq_req.waddr;
            port_req.wdata = seq_req.wdata;
            port_req.raddr = seq_req.raddr;
        end

        if (vec_req_valid) begin
            port_req.raddr = vec_raddr;    // Redirect target
        end

        if (inst_grant) begin
            port_req.we    = 1'b1;
            port_req.op    = csr_op;
            port_req.waddr = csr_addr;
            port_req.wdata = inst_wdata;
            port_req.raddr = csr_addr;
        end
    end

    // Both peers see the same read data
    assign rdata = port_rdata;

    // A colliding instruction never displaces the sequencer write
    seq_owns_write: assert property (
        @(posedge clk)
        (seq_req_valid && seq_req.we && csr_rw)
            |-> (port_req.we && port_req.op == seq_req.op
                 && port_req.waddr == seq_req.waddr
                 && port_req.wdata == seq_req.wdata)
    ) else $error("CSR instruction granted during a sequencer write");

endmodule

// ==== src/csr_file.sv ====
module csr_file #(
    parameter csr_pkg::csr_data_t reset_vector = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_req_t  req,
    output csr_pkg::csr_data_t rdata,
    output csr_pkg::csr_data_t mstatus
);

    csr_pkg::csr_data_t mstatus_q;
    csr_pkg::csr_data_t mie_q;
    csr_pkg::csr_data_t mtvec_q;
    csr_pkg::csr_data_t mepc_q;
    csr_pkg::csr_data_t mcause_q;
    csr_pkg::csr_data_t mtval_q;
    csr_pkg::csr_data_t mip_q;

    csr_pkg::csr_data_t old_val;    // Current contents at the write address
    csr_pkg::csr_data_t new_val;

    // Unimplemented addresses read as zero
    function automatic csr_pkg::csr_data_t lookup(input csr_pkg::csr_addr_t addr);
        csr_pkg::csr_data_t val;
        case (addr)
            csr_pkg::addr_mstatus: val = mstatus_q;
            csr_pkg::addr_mie:     val = mie_q;
            csr_pkg::addr_mtvec:   val = mtvec_q;
            csr_pkg::addr_mepc:    val = mepc_q;
            csr_pkg::addr_mcause:  val = mcause_q;
            csr_pkg::addr_mtval:   val = mtval_q;
            csr_pkg::addr_mip:     val = mip_q;
            default:               val = '0;
        endcase
        return val;
    endfunction

    always_comb begin
        rdata   = lookup(req.raddr);    // Old value, the write lands at the edge
        old_val = lookup(req.waddr);
    end

    always_comb begin
        case (req.op)
            csr_pkg::op_write: new_val = req.wdata;
            csr_pkg::op_set:   new_val = old_val | req.wdata;
            csr_pkg::op_clear: new_val = old_val & ~req.wdata;
            default:           new_val = old_val;
        endcase
    end

    // ##########################################################################
    // Register storage
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= reset_vector;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtval_q   <= '0;
            mip_q     <= '0;
        end else if (req.we) begin
            case (req.waddr)
                csr_pkg::addr_mstatus: mstatus_q <= new_val;
                csr_pkg::addr_mie:     mie_q     <= new_val;
                csr_pkg::addr_mtvec:   mtvec_q   <= new_val;
                csr_pkg::addr_mepc:    mepc_q    <= new_val;
                csr_pkg::addr_mcause:  mcause_q  <= new_val;
                csr_pkg::addr_mtval:   mtval_q   <= new_val;
                csr_pkg::addr_mip:     mip_q     <= new_val;
                default: ;                          // No such CSR
            endcase
        end
    end

    assign mstatus = mstatus_q;

    // Only direct mode exists, so mtvec must stay word aligned with MODE = 0
    mtvec_direct_mode: assert property (
        @(posedge clk) disable iff (rst)
        (req.we && req.waddr == csr_pkg::addr_mtvec) |-> (new_val[1:0] == 2'b00)
    ) else $error("mtvec written with a non-direct mode");

endmodule

// ==== src/trap_pkg.sv ====
package trap_pkg;

    // ##########################################################################
    // Trap causes
    // ##########################################################################

    // Already qualified by the pipeline, any flag set starts a trap
    typedef struct packed {
        logic interrupt;
        logic illegal_inst;
        logic load_fault;
        logic store_fault;
        logic ecall;
    } trap_cause_t;

    // mcause values
    localparam csr_pkg::csr_data_t code_illegal     = 32'd2;
    localparam csr_pkg::csr_data_t code_load_fault  = 32'd5;
    localparam csr_pkg::csr_data_t code_store_fault = 32'd7;
    localparam csr_pkg::csr_data_t code_ecall       = 32'd11;
    localparam csr_pkg::csr_data_t code_interrupt   = 32'h8000_000B;   // Interrupt bit plus 11

    // ##########################################################################
    // Pipeline control
    // ##########################################################################

    typedef struct packed {
        logic fd;
        logic de;
        logic em;
        logic mw;
        logic regwrite_cancel;    // Suppress writeback of the faulting instruction
    } flush_t;

    typedef enum logic [1:0] {
        idle,
        save_epc,
        save_cause
    } trap_state_t;

endpackage

// ==== src/csr_pkg.sv ====
package csr_pkg;

    // ##########################################################################
    // Widths
    // ##########################################################################

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [4:0]  csr_imm_t;    // zimm field of CSRRWI/CSRRSI/CSRRCI

    // ##########################################################################
    // Machine CSR addresses
    // ##########################################################################

    localparam csr_addr_t addr_mstatus = 12'h300;
    localparam csr_addr_t addr_mie     = 12'h304;
    localparam csr_addr_t addr_mtvec   = 12'h305;
    localparam csr_addr_t addr_mepc    = 12'h341;
    localparam csr_addr_t addr_mcause  = 12'h342;
    localparam csr_addr_t addr_mtval   = 12'h343;
    localparam csr_addr_t addr_mip     = 12'h344;

    // mstatus fields
    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;

    // Matches funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        op_write = 2'b01,
        op_set   = 2'b10,
        op_clear = 2'b11
    } csr_op_t;

    // One request on the shared CSR file port
    typedef struct packed {
        logic      we;
        csr_op_t   op;
        csr_addr_t waddr;
        csr_data_t wdata;
        csr_addr_t raddr;
    } csr_req_t;

endpackage
